// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary -j 0 -Wno-fatal
TOP      ?= pkt_check_tb
FILELIST ?= filelist.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := All tests passed!

SRCS := $(wildcard hdl/*.sv) $(wildcard bench/*.sv) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass or fail from the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/pkt_check_model.svh
`ifndef PKT_CHECK_MODEL_SVH
`define PKT_CHECK_MODEL_SVH

//////////////////////////////
// Header encode
//////////////////////////////
// Check bits over the protected byte {pkt_type, byte_cnt}
function automatic logic [3:0] ecc_bits(input logic [7:0] d);
	logic [3:0] c;
	c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
	c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
	c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
	c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
	return c;
endfunction

// Clean header half word, parity bit sits above pkt_type
function automatic logic [15:0] build_header(input logic [3:0] cnt, input logic [3:0] typ,
	input logic [2:0] sop);
	logic [7:0] d;
	d = {typ, cnt};
	return {sop, ^d, typ, cnt, ecc_bits(d)};
endfunction

// Serial CRC-8, one message bit per step, MSB first
function automatic logic [7:0] crc_bits(input logic [7:0] crc, input logic [7:0] b);
	logic [7:0] c;
	logic fb;
	c = crc;
	for (int i = 7; i >= 0; i--) begin
		fb = c[7] ^ b[i];
		c = {c[6:0], 1'b0};
		if (fb)
			c = c ^ CRC_POLY_DEF;
	end
	return c;
endfunction

//////////////////////////////
// Reference model
//////////////////////////////
// Expected verdict straight from the memory image
function automatic check_result_t expect_result(input logic [ADDR_W-1:0] a);
	logic [15:0] h;
	logic [7:0] d;
	logic [3:0] syn;
	logic par;
	int idx;
	logic [ADDR_W-1:0] w;
	check_result_t r;
	h = mem[a][15:0];
	d = h[11:4];
	syn = ecc_bits(d) ^ h[3:0];
	par = (^d) ^ h[12];
	// Hamming position of each data bit
	case (syn)
		4'd3: idx = 0;
		4'd5: idx = 1;
		4'd6: idx = 2;
		4'd7: idx = 3;
		4'd9: idx = 4;
		4'd10: idx = 5;
		4'd11: idx = 6;
		4'd12: idx = 7;
		default: idx = -1;
	endcase
	if (par && idx >= 0)
		d[idx] = ~d[idx];
	r = '0;
	r.ecc_corr = par;
	r.ecc_uncorr = !par && (syn != 4'd0);
	r.byte_cnt = d[3:0];
	r.pkt_type = d[7:4];
	// No payload walk when the length is not trustworthy
	if (!r.ecc_uncorr) begin
		w = a + ADDR_W'(HDR_DATA_OFS);
		for (int i = 0; i < int'(d[3:0]); i++) begin
			r.crc_calc = crc_bits(r.crc_calc, mem[w][7:0]);
			w = w + ADDR_W'(1);
		end
		r.crc_ext = mem[w][7:0];
		r.crc_err = (r.crc_calc != r.crc_ext);
	end
	return r;
endfunction

// STATUS image, busy in bit 0 and pkt_type on top
function automatic logic [31:0] status_word(input check_result_t r, input logic busy,
	input logic done);
	return {16'h0, r.pkt_type, r.byte_cnt, 3'b000, r.crc_err, r.ecc_uncorr, r.ecc_corr,
		done, busy};
endfunction

function automatic apb_rsp_t make_rsp(input logic err, input logic [31:0] data);
	apb_rsp_t r;
	r.pready = 1'b1;
	r.pslverr = err;
	r.prdata = data;
	return r;
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////
task automatic check_result(input string name, input check_result_t exp,
	input check_result_t act);
	if (act !== exp) begin
		$display("ERR %s: expected %h actual %h", name, exp, act);
		result_errs++;
	end
endtask

task automatic check_apb_rsp(input string name, input apb_rsp_t exp, input apb_rsp_t act);
	if (act !== exp) begin
		$display("ERR %s: expected %h actual %h", name, exp, act);
		apb_errs++;
	end
endtask

`endif

// File: bench/pkt_check_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_check_tb
	import pkt_check_pkg::*;
();

	localparam int ADDR_W = ADDR_W_DEF;
	localparam int MEM_WORDS = 1 << ADDR_W;
	// Packets per test
	localparam int N_CLEAN = 8;
	localparam int N_CRC = 4;
	localparam int N_SINGLE = 6;
	localparam int N_DOUBLE = 4;
	localparam int N_PKT = N_CLEAN + N_CRC + N_SINGLE + N_DOUBLE + 1;
	localparam int CYCLE_LIMIT = 200 * N_PKT;
	// Quiet time that would expose a second check
	localparam int IRQ_WINDOW = 60;

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic mem_rd;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_rdata = '0;
	logic irq;

	// Memory image and its read pipe
	logic [DATA_W-1:0] mem [0:MEM_WORDS-1];
	logic rd_pend = 1'b0;
	logic [ADDR_W-1:0] rd_addr;
	int rd_count = 0;

	int seed;
	int cycles = 0;
	int irq_rises = 0;
	logic irq_prev = 1'b0;
	// Verdict left in the result registers by the last check
	check_result_t last_exp = '0;
	int result_errs = 0;
	int apb_errs = 0;
	int other_errs = 0;

	`include "pkt_check_model.svh"

	pkt_check_top i_pkt_check_top (
		.clk         (clk),
		.reset       (reset),
		.apb_i       (apb_req),
		.apb_o       (apb_rsp),
		.mem_rd_o    (mem_rd),
		.mem_addr_o  (mem_addr),
		.mem_rdata_i (mem_rdata),
		.irq_o       (irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// Memory and monitors
	//////////////////////////////
	// Read seen mid cycle, word shows up one cycle later
	always @(negedge clk) begin
		if (rd_pend)
			mem_rdata <= mem[rd_addr];
		// Every issued read counted
		if (mem_rd === 1'b1)
			rd_count <= rd_count + 1;
		rd_pend <= mem_rd;
		rd_addr <= mem_addr;
	end

	// Interrupt rising edges
	always @(negedge clk) begin
		if (irq && !irq_prev)
			irq_rises <= irq_rises + 1;
		irq_prev <= irq;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the checker never raised irq_o", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	//////////////////////////////
	// APB and packet tasks
	//////////////////////////////
	// Setup, access, then idle; response taken mid access cycle
	task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
		output apb_rsp_t rsp);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1;
		rsp = apb_rsp;
		@(negedge clk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic reg_write(input string name, input logic [31:0] addr, input logic [31:0] data);
		apb_rsp_t rsp;
		apb_xfer(1'b1, addr, data, rsp);
		check_apb_rsp(name, make_rsp(1'b0, 32'h0), rsp);
	endtask

	task automatic wait_irq();
		while (irq !== 1'b1)
			@(negedge clk);
	endtask

	// Random spot, random payload, header and CRC byte xor'd with the flip masks
	task automatic new_packet(input logic [3:0] cnt, input logic [15:0] hdr_flip,
		input logic [7:0] crc_flip, output logic [ADDR_W-1:0] a);
		logic [31:0] rnd;
		logic [7:0] crc;
		logic [ADDR_W-1:0] w;
		rnd = $random(seed);
		a = {1'b0, rnd[ADDR_W-2:0]};
		rnd = $random(seed);
		mem[a] = {rnd[31:16], build_header(cnt, rnd[3:0], rnd[6:4]) ^ hdr_flip};
		crc = 8'h00;
		w = a + ADDR_W'(HDR_DATA_OFS);
		for (int i = 0; i < int'(cnt); i++) begin
			rnd = $random(seed);
			mem[w] = rnd;
			crc = crc_bits(crc, rnd[7:0]);
			w = w + ADDR_W'(1);
		end
		rnd = $random(seed);
		mem[w] = {rnd[31:8], crc ^ crc_flip};
	endtask

	// One full check through APB, optional second start while busy
	task automatic run_check(input string name, input logic [ADDR_W-1:0] a, input logic twice);
		check_result_t exp;
		check_result_t act;
		apb_rsp_t rsp;
		logic [31:0] st;
		int rises;
		int reads;
		int exp_reads;
		exp = expect_result(a);
		// Header, one word per payload byte, then the CRC word
		exp_reads = exp.ecc_uncorr ? 1 : int'(exp.byte_cnt) + 2;
		rises = irq_rises;
		reads = rd_count;
		reg_write(name, REG_HDR_ADDR, 32'(a));
		apb_xfer(1'b0, REG_HDR_ADDR, 32'h0, rsp);
		check_apb_rsp(name, make_rsp(1'b0, 32'(a)), rsp);
		reg_write(name, REG_CTRL, 32'h1);
		if (twice) begin
			reg_write(name, REG_CTRL, 32'h1);
			// Still running, previous verdict held
			apb_xfer(1'b0, REG_STATUS, 32'h0, rsp);
			check_apb_rsp(name, make_rsp(1'b0, status_word(last_exp, 1'b1, 1'b0)), rsp);
		end
		wait_irq();
		if (twice)
			repeat (IRQ_WINDOW) @(negedge clk);
		apb_xfer(1'b0, REG_STATUS, 32'h0, rsp);
		check_apb_rsp(name, make_rsp(1'b0, status_word(exp, 1'b0, 1'b1)), rsp);
		st = rsp.prdata;
		apb_xfer(1'b0, REG_CRC, 32'h0, rsp);
		check_apb_rsp(name, make_rsp(1'b0, {16'h0, exp.crc_ext, exp.crc_calc}), rsp);
		act = '0;
		act.ecc_corr = st[2];
		act.ecc_uncorr = st[3];
		act.crc_err = st[4];
		act.byte_cnt = st[11:8];
		act.pkt_type = st[15:12];
		act.crc_calc = rsp.prdata[7:0];
		act.crc_ext = rsp.prdata[15:8];
		check_result(name, exp, act);
		if (irq_rises - rises != 1) begin
			$display("ERR %s: expected 1 interrupt actual %0d", name, irq_rises - rises);
			other_errs++;
		end
		if (rd_count - reads != exp_reads) begin
			$display("ERR %s: expected %0d memory reads actual %0d", name, exp_reads,
				rd_count - reads);
			other_errs++;
		end
		reg_write(name, REG_CTRL, 32'h2);
		if (irq !== 1'b0) begin
			$display("%s: irq_o still high after the clear write", name);
			other_errs++;
		end
		last_exp = exp;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		apb_rsp_t rsp;
		logic [31:0] rnd;
		logic [ADDR_W-1:0] a;
		int b1;
		int b2;
		seed = 32'h2fc784a8;
		reset = 1'b1;
		apb_req = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[ADDR_W'(i)] = 32'hA500_0000 ^ 32'(i);
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Quiet state out of reset
		apb_xfer(1'b0, REG_STATUS, 32'h0, rsp);
		check_apb_rsp("reset", make_rsp(1'b0, 32'h0), rsp);
		if (irq !== 1'b0 || mem_rd !== 1'b0) begin
			$display("irq_o or mem_rd_o not low after reset");
			other_errs++;
		end

		for (int n = 0; n < N_CLEAN; n++) begin
			rnd = $random(seed);
			new_packet(rnd[3:0], 16'h0, 8'h0, a);
			run_check("clean", a, 1'b0);
		end

		// Any non-zero xor on the stored CRC byte
		for (int n = 0; n < N_CRC; n++) begin
			rnd = $random(seed);
			new_packet(rnd[3:0], 16'h0, rnd[15:8] | 8'h01, a);
			run_check("crc_bad", a, 1'b0);
		end

		// One of the 13 coded bits, check, data or parity
		for (int n = 0; n < N_SINGLE; n++) begin
			rnd = $random(seed);
			b1 = int'(rnd[15:8] % 8'd13);
			new_packet(rnd[3:0], 16'h1 << b1, 8'h0, a);
			run_check("ecc_single", a, 1'b0);
		end

		// Two distinct data bits, header bits 4 to 11
		for (int n = 0; n < N_DOUBLE; n++) begin
			rnd = $random(seed);
			b1 = int'(rnd[10:8]);
			b2 = (b1 + 1 + int'(rnd[14:12] % 3'd7)) % 8;
			new_packet(rnd[3:0], (16'h10 << b1) | (16'h10 << b2), 8'h0, a);
			run_check("ecc_double", a, 1'b0);
		end

		// Unmapped offset both ways
		apb_xfer(1'b1, 32'h10, 32'h1, rsp);
		check_apb_rsp("apb_bad_wr", make_rsp(1'b1, 32'h0), rsp);
		apb_xfer(1'b0, 32'h10, 32'h0, rsp);
		check_apb_rsp("apb_bad_rd", make_rsp(1'b1, 32'h0), rsp);

		// Longest packet so the second start lands mid check
		new_packet(4'd15, 16'h0, 8'h0, a);
		run_check("apb_busy_start", a, 1'b1);

		$display("Errors: %0d result, %0d apb, %0d other", result_errs, apb_errs, other_errs);
		if (result_errs + apb_errs + other_errs == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hdl/pkt_check_pkg.sv
hdl/pkt_hdr_decode.sv
hdl/pkt_crc_execute.sv
hdl/pkt_result_regs.sv
hdl/pkt_check_top.sv
bench/pkt_check_tb.sv

// File: hdl/pkt_check_pkg.sv
`default_nettype none

package pkt_check_pkg;

	//////////////////////////////
	// Widths and defaults
	//////////////////////////////
	localparam int ADDR_W_DEF = 14;
	localparam int DATA_W = 32;
	// CRC-8 MSB first, zero init, no final xor
	localparam logic [7:0] CRC_POLY_DEF = 8'h07;

	// APB register offsets
	localparam logic [31:0] REG_CTRL = 32'h0;
	localparam logic [31:0] REG_HDR_ADDR = 32'h4;
	localparam logic [31:0] REG_STATUS = 32'h8;
	localparam logic [31:0] REG_CRC = 32'hC;

	// CTRL bits
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_CLEAR_BIT = 1;

	// First payload word sits two words past the header
	localparam int HDR_DATA_OFS = 2;

	//////////////////////////////
	// Structs
	//////////////////////////////
	// Header word bits [15:0], ecc_code in the low nibble
	typedef struct packed {
		logic [2:0] sop;
		logic ecc_msb;
		logic [3:0] pkt_type;
		logic [3:0] byte_cnt;
		logic [3:0] ecc_code;
	} hdr_fields_t;

	// Decode stage output, data fields already corrected
	typedef struct packed {
		logic [3:0] byte_cnt;
		logic [3:0] pkt_type;
		logic [2:0] sop;
		logic ecc_corr;
		logic ecc_uncorr;
		logic [3:0] syndrome;
	} hdr_decoded_t;

	// Verdict of one check
	typedef struct packed {
		logic ecc_corr;
		logic ecc_uncorr;
		logic crc_err;
		logic [3:0] byte_cnt;
		logic [3:0] pkt_type;
		logic [7:0] crc_calc;
		logic [7:0] crc_ext;
	} check_result_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

	// One data byte into the CRC, bit 7 shifted out first
	function automatic logic [7:0] crc8_step(
		input logic [7:0] crc_in,
		input logic [7:0] data_in,
		input logic [7:0] poly
	);
		logic [7:0] c;
		c = crc_in ^ data_in;
		for (int i = 0; i < 8; i++) begin
			if (c[7])
				c = (c << 1) ^ poly;
			else
				c = c << 1;
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// File: hdl/pkt_check_top.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_check_top
	import pkt_check_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter logic [7:0] CRC_POLY = CRC_POLY_DEF
) (
	input logic clk,
	input logic reset,
	input apb_req_t apb_i,
	output apb_rsp_t apb_o,
	output logic mem_rd_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	input logic [DATA_W-1:0] mem_rdata_i,
	output logic irq_o
);

	// Between stages
	hdr_decoded_t hdr_dec;
	logic start;
	logic [ADDR_W-1:0] hdr_addr;
	logic busy;
	logic done;
	check_result_t result;

	//////////////////////////////
	// Decode
	//////////////////////////////
	// Looks at every returned word, execute picks the header cycle
	pkt_hdr_decode i_pkt_hdr_decode (
		.hdr_word_i (mem_rdata_i),
		.hdr_o      (hdr_dec)
	);

	//////////////////////////////
	// Execute
	//////////////////////////////
	pkt_crc_execute #(
		.ADDR_W   (ADDR_W),
		.CRC_POLY (CRC_POLY)
	) i_pkt_crc_execute (
		.clk         (clk),
		.reset       (reset),
		.start_i     (start),
		.hdr_addr_i  (hdr_addr),
		.hdr_i       (hdr_dec),
		.mem_rdata_i (mem_rdata_i),
		.mem_rd_o    (mem_rd_o),
		.mem_addr_o  (mem_addr_o),
		.busy_o      (busy),
		.done_o      (done),
		.result_o    (result)
	);

	//////////////////////////////
	// Result and APB
	//////////////////////////////
	pkt_result_regs #(
		.ADDR_W (ADDR_W)
	) i_pkt_result_regs (
		.clk        (clk),
		.reset      (reset),
		.apb_i      (apb_i),
		.apb_o      (apb_o),
		.busy_i     (busy),
		.done_i     (done),
		.result_i   (result),
		.start_o    (start),
		.hdr_addr_o (hdr_addr),
		.irq_o      (irq_o)
	);

endmodule

`default_nettype wire

// File: hdl/pkt_crc_execute.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_crc_execute
	import pkt_check_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter logic [7:0] CRC_POLY = CRC_POLY_DEF
) (
	input logic clk,
	input logic reset,
	input logic start_i,
	input logic [ADDR_W-1:0] hdr_addr_i,
	input hdr_decoded_t hdr_i,
	input logic [DATA_W-1:0] mem_rdata_i,
	output logic mem_rd_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output logic busy_o,
	output logic done_o,
	output check_result_t result_o
);

	typedef enum logic [1:0] {
		IDLE,
		HDR_READ,
		CRC_CALC,
		COMPARE
	} state_t;

	state_t state_q;
	// Read issue and data return one cycle later
	logic rd_q;
	logic rvalid_q;
	logic done_q;
	logic ecc_corr_q;
	logic ecc_uncorr_q;
	logic crc_err_q;

	logic [ADDR_W-1:0] addr_q;
	// Payload words still to be read
	logic [3:0] rem_q;
	logic [3:0] byte_cnt_q;
	logic [3:0] pkt_type_q;
	logic [7:0] crc_q;
	logic [7:0] crc_ext_q;

	//////////////////////////////
	// FSM
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			rd_q <= 1'b0;
			rvalid_q <= 1'b0;
			done_q <= 1'b0;
			ecc_corr_q <= 1'b0;
			ecc_uncorr_q <= 1'b0;
			crc_err_q <= 1'b0;
		end else begin
			rvalid_q <= rd_q;
			rd_q <= 1'b0;
			done_q <= 1'b0;
			case (state_q)
				IDLE: begin
					// Issue the header read right away
					if (start_i) begin
						rd_q <= 1'b1;
						ecc_corr_q <= 1'b0;
						ecc_uncorr_q <= 1'b0;
						crc_err_q <= 1'b0;
						state_q <= HDR_READ;
					end
				end
				HDR_READ: begin
					if (rvalid_q) begin
						ecc_corr_q <= hdr_i.ecc_corr;
						ecc_uncorr_q <= hdr_i.ecc_uncorr;
						// Length cannot be trusted so stop here
						if (hdr_i.ecc_uncorr) begin
							done_q <= 1'b1;
							state_q <= IDLE;
						end else begin
							rd_q <= 1'b1;
							state_q <= CRC_CALC;
						end
					end
				end
				CRC_CALC: begin
					// One word in flight at a time
					if (rvalid_q) begin
						if (rem_q != '0)
							rd_q <= 1'b1;
						else
							state_q <= COMPARE;
					end
				end
				COMPARE: begin
					crc_err_q <= (crc_q != crc_ext_q);
					done_q <= 1'b1;
					state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Address and CRC datapath
	//////////////////////////////
	always_ff @(posedge clk) begin
		case (state_q)
			IDLE: begin
				if (start_i) begin
					addr_q <= hdr_addr_i;
					crc_q <= '0;
					crc_ext_q <= '0;
				end
			end
			HDR_READ: begin
				// Corrected byte count sets the payload length
				if (rvalid_q) begin
					byte_cnt_q <= hdr_i.byte_cnt;
					pkt_type_q <= hdr_i.pkt_type;
					rem_q <= hdr_i.byte_cnt;
					addr_q <= addr_q + ADDR_W'(HDR_DATA_OFS);
				end
			end
			CRC_CALC: begin
				if (rvalid_q) begin
					// Low byte of each payload word
					if (rem_q != '0) begin
						crc_q <= crc8_step(crc_q, mem_rdata_i[7:0], CRC_POLY);
						rem_q <= rem_q - 1'b1;
						addr_q <= addr_q + 1'b1;
					end else begin
						// Word after the payload holds the stored CRC
						crc_ext_q <= mem_rdata_i[7:0];
					end
				end
			end
			default: ;
		endcase
	end

	assign mem_rd_o = rd_q;
	assign mem_addr_o = addr_q;
	assign busy_o = (state_q != IDLE);
	assign done_o = done_q;

	always_comb begin
		result_o.ecc_corr = ecc_corr_q;
		result_o.ecc_uncorr = ecc_uncorr_q;
		result_o.crc_err = crc_err_q;
		result_o.byte_cnt = byte_cnt_q;
		result_o.pkt_type = pkt_type_q;
		result_o.crc_calc = crc_q;
		result_o.crc_ext = crc_ext_q;
	end

endmodule

`default_nettype wire

// File: hdl/pkt_hdr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_hdr_decode
	import pkt_check_pkg::*;
(
	input logic [DATA_W-1:0] hdr_word_i,
	output hdr_decoded_t hdr_o
);

	// Syndrome value that points at each data bit
	localparam logic [3:0] SYN_POS [0:7] = '{
		4'd3, 4'd5, 4'd6, 4'd7, 4'd9, 4'd10, 4'd11, 4'd12
	};

	hdr_fields_t fld;
	logic [7:0] data;
	logic [3:0] chk_calc;
	logic [3:0] syndrome;
	logic par_err;
	logic [7:0] data_fix;

	// Only the low half word is header
	// Upper half is ignored here
	assign fld = hdr_fields_t'(hdr_word_i[15:0]);

	// Protected byte is {pkt_type, byte_cnt}
	assign data = {fld.pkt_type, fld.byte_cnt};

	//////////////////////////////
	// Check bits and syndrome
	//////////////////////////////
	assign chk_calc[0] = data[0] ^ data[1] ^ data[3] ^ data[4] ^ data[6];
	assign chk_calc[1] = data[0] ^ data[2] ^ data[3] ^ data[5] ^ data[6];
	assign chk_calc[2] = data[1] ^ data[2] ^ data[3] ^ data[7];
	assign chk_calc[3] = data[4] ^ data[5] ^ data[6] ^ data[7];

	assign syndrome = chk_calc ^ fld.ecc_code;

	// Overall parity of received data against stored msb
	assign par_err = (^data) ^ fld.ecc_msb;

	//////////////////////////////
	// Single bit correction
	//////////////////////////////
	// Flip the data bit named by the syndrome
	// Power of two syndromes match no entry so a check bit error keeps data
	always_comb begin
		data_fix = data;
		if (par_err && (syndrome != '0)) begin
			for (int i = 0; i < 8; i++) begin
				if (syndrome == SYN_POS[i])
					data_fix[i] = ~data[i];
			end
		end
	end

	// Parity mismatch means one error, zero syndrome is a parity bit hit
	// Matching parity with a syndrome means two errors
	always_comb begin
		hdr_o.byte_cnt = data_fix[3:0];
		hdr_o.pkt_type = data_fix[7:4];
		hdr_o.sop = fld.sop;
		hdr_o.ecc_corr = par_err;
		hdr_o.ecc_uncorr = !par_err && (syndrome != '0);
		hdr_o.syndrome = syndrome;
	end

endmodule

`default_nettype wire

// File: hdl/pkt_result_regs.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_result_regs
	import pkt_check_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF
) (
	input logic clk,
	input logic reset,
	input apb_req_t apb_i,
	output apb_rsp_t apb_o,
	input logic busy_i,
	input logic done_i,
	input check_result_t result_i,
	output logic start_o,
	output logic [ADDR_W-1:0] hdr_addr_o,
	output logic irq_o
);

	logic acc;
	logic addr_ok;
	logic wr_en;
	logic start_req;
	logic clr_req;
	logic [DATA_W-1:0] rdata;

	logic start_q;
	logic done_q;
	logic [ADDR_W-1:0] hdr_addr_q;
	check_result_t res_q;

	//////////////////////////////
	// APB decode
	//////////////////////////////
	// Access phase of a transfer
	assign acc = apb_i.psel && apb_i.penable;

	always_comb begin
		addr_ok = apb_i.paddr inside {REG_CTRL, REG_HDR_ADDR, REG_STATUS, REG_CRC};
	end

	// Writes to unknown offsets are dropped
	assign wr_en = acc && apb_i.pwrite && addr_ok;

	// Start only when idle and no start already on its way
	assign start_req = wr_en && (apb_i.paddr == REG_CTRL)
		&& apb_i.pwdata[CTRL_START_BIT] && !busy_i && !start_q;
	assign clr_req = wr_en && (apb_i.paddr == REG_CTRL)
		&& apb_i.pwdata[CTRL_CLEAR_BIT];

	//////////////////////////////
	// Registers
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			start_q <= 1'b0;
			done_q <= 1'b0;
			hdr_addr_q <= '0;
			res_q <= '0;
		end else begin
			// One cycle pulse after the CTRL write
			start_q <= start_req;
			if (wr_en && (apb_i.paddr == REG_HDR_ADDR))
				hdr_addr_q <= apb_i.pwdata[ADDR_W-1:0];
			// Verdict capture wins over a clear in the same cycle
			if (done_i) begin
				done_q <= 1'b1;
				res_q <= result_i;
			end else if (clr_req || start_q) begin
				done_q <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Read mux
	//////////////////////////////
	// CTRL reads back as zero
	always_comb begin
		rdata = '0;
		case (apb_i.paddr)
			REG_HDR_ADDR: rdata[ADDR_W-1:0] = hdr_addr_q;
			REG_STATUS: rdata = {16'h0, res_q.pkt_type, res_q.byte_cnt, 3'b000,
				res_q.crc_err, res_q.ecc_uncorr, res_q.ecc_corr, done_q, busy_i};
			REG_CRC: rdata = {16'h0, res_q.crc_ext, res_q.crc_calc};
			default: rdata = '0;
		endcase
	end

	// No wait states
	assign apb_o.pready = 1'b1;
	assign apb_o.pslverr = acc && !addr_ok;
	assign apb_o.prdata = (acc && !apb_i.pwrite && addr_ok) ? rdata : '0;

	assign start_o = start_q;
	assign hdr_addr_o = hdr_addr_q;
	// Interrupt follows done until cleared or restarted
	assign irq_o = done_q;

endmodule

`default_nettype wire
